// File: include/l2_ops.svh
// Request op codes and requesting unit ids of the L2 pipeline
// Op codes are 3 bits wide and unit ids 2 bits, as in l2_dir_pkg
`ifndef L2_OPS_SVH
`define L2_OPS_SVH

`define OP_LOAD        3'd0
`define OP_LOAD_SYNC   3'd1
`define OP_STORE       3'd2
`define OP_STORE_SYNC  3'd3
`define OP_FLUSH       3'd4

`define UNIT_ICACHE    2'd0
`define UNIT_DCACHE    2'd1

`endif

// File: design/l2_dir_pkg.sv
// Widths and types of the L2 directory stage
// Sized for 16 L2 sets, 8 L1 sets and 4 ways in both caches
package l2_dir_pkg;

	localparam int ADDR_W   = 16;
	localparam int L2_SET_W = 4;
	localparam int L2_TAG_W = ADDR_W - L2_SET_W;
	localparam int L1_SET_W = 3;
	localparam int L1_TAG_W = ADDR_W - L1_SET_W;
	localparam int NUM_WAYS = 4;

	// Line address, the tag bits sit above the set index bits
	typedef logic [ADDR_W-1:0] line_addr_t;

	typedef logic [L2_TAG_W-1:0] l2_tag_t;
	typedef logic [L2_SET_W-1:0] l2_set_t;
	typedef logic [L1_TAG_W-1:0] l1_tag_t;
	typedef logic [L1_SET_W-1:0] l1_set_t;

	// Way index and one-hot way set, shared by L2 and L1
	typedef logic [1:0] way_t;
	typedef logic [NUM_WAYS-1:0] way_mask_t;

	typedef logic [2:0] req_op_t;
	typedef logic [1:0] unit_t;

	// The L1 directory walks all sets after reset before taking requests
	typedef enum logic
	{
		CLEARING,
		READY
	} dir_state_t;

endpackage

// File: design/l2_way_state.sv
// Dirty bits are cleared by reset; tags and valid bits come from the tag stage
// Assumes the four way tags differ, so at most one way hits
`timescale 1ns/1ps
`include "l2_ops.svh"

module l2_way_state (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   stall_i,
	input  logic                   req_valid_i,
	input  l2_dir_pkg::req_op_t    req_op_i,
	input  l2_dir_pkg::line_addr_t req_addr_i,
	input  logic                   has_fill_i,
	input  l2_dir_pkg::way_t       fill_way_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag0_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag1_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag2_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag3_i,
	input  logic                   l2_valid0_i,
	input  logic                   l2_valid1_i,
	input  logic                   l2_valid2_i,
	input  logic                   l2_valid3_i,
	output l2_dir_pkg::way_mask_t  way_hit_o,
	output logic                   l2_hit_o,
	output logic                   dirty0_o,
	output logic                   dirty1_o,
	output logic                   dirty2_o,
	output logic                   dirty3_o
);

	l2_dir_pkg::l2_tag_t   req_tag;
	l2_dir_pkg::l2_set_t   req_set;
	l2_dir_pkg::l2_tag_t   way_tag [l2_dir_pkg::NUM_WAYS];
	l2_dir_pkg::way_mask_t way_valid;
	l2_dir_pkg::way_mask_t dirty_target;
	l2_dir_pkg::way_mask_t dirty_next;
	l2_dir_pkg::way_mask_t dirty_q;
	// One bit per way for every L2 set
	l2_dir_pkg::way_mask_t dirty_mem [2**l2_dir_pkg::L2_SET_W];
	logic                  accept;
	logic                  is_store;
	logic                  is_flush;
	logic                  update_dirty;
	logic                  new_dirty;

	assign req_tag = req_addr_i[l2_dir_pkg::ADDR_W-1 -: l2_dir_pkg::L2_TAG_W];
	assign req_set = req_addr_i[l2_dir_pkg::L2_SET_W-1:0];

	assign way_tag[0] = l2_tag0_i;
	assign way_tag[1] = l2_tag1_i;
	assign way_tag[2] = l2_tag2_i;
	assign way_tag[3] = l2_tag3_i;
	assign way_valid  = {l2_valid3_i, l2_valid2_i, l2_valid1_i, l2_valid0_i};

	always_comb
	begin
		for (int w = 0; w < l2_dir_pkg::NUM_WAYS; w++)
			way_hit_o[w] = way_valid[w] && (way_tag[w] == req_tag);
	end

	assign l2_hit_o = |way_hit_o;

	assign is_store = (req_op_i == `OP_STORE) || (req_op_i == `OP_STORE_SYNC);
	assign is_flush = (req_op_i == `OP_FLUSH);
	assign accept   = req_valid_i && !stall_i;

	assign update_dirty = accept && (has_fill_i || (l2_hit_o && (is_store || is_flush)));

	// A fill writes the way it lands in, anything else writes the hit way
	assign dirty_target = has_fill_i ? (l2_dir_pkg::way_mask_t'(1) << fill_way_i) : way_hit_o;

	always_comb
	begin
		if (has_fill_i)
			new_dirty = is_store;
		else if (is_flush)
			new_dirty = 1'b0;
		else
			new_dirty = 1'b1;
	end

	// Bypass the written value so the output already shows the update
	always_comb
	begin
		for (int w = 0; w < l2_dir_pkg::NUM_WAYS; w++)
			dirty_next[w] = (update_dirty && dirty_target[w]) ? new_dirty : dirty_mem[req_set][w];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int s = 0; s < 2**l2_dir_pkg::L2_SET_W; s++)
				dirty_mem[s] <= '0;
			dirty_q <= '0;
		end
		else if (!stall_i)
		begin
			if (update_dirty)
				dirty_mem[req_set] <= dirty_next;
			// An invalid way never reports dirty
			dirty_q <= dirty_next & way_valid;
		end
	end

	assign dirty0_o = dirty_q[0];
	assign dirty1_o = dirty_q[1];
	assign dirty2_o = dirty_q[2];
	assign dirty3_o = dirty_q[3];

endmodule

// File: design/l1_dir_tags.sv
// Copy of the L1 data cache tags of one core; no invalidation path
// Requests are ignored for 8 cycles after reset while the sets are cleared
`timescale 1ns/1ps
`include "l2_ops.svh"

module l1_dir_tags (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   stall_i,
	input  logic                   req_valid_i,
	input  l2_dir_pkg::unit_t      req_unit_i,
	input  l2_dir_pkg::req_op_t    req_op_i,
	input  l2_dir_pkg::line_addr_t req_addr_i,
	input  l2_dir_pkg::way_t       req_l1_way_i,
	input  logic                   has_fill_i,
	input  logic                   l2_hit_i,
	output logic                   l1_has_line_o,
	output l2_dir_pkg::way_t       l1_way_o
);

	l2_dir_pkg::l1_tag_t    tag_mem [2**l2_dir_pkg::L1_SET_W][l2_dir_pkg::NUM_WAYS];
	l2_dir_pkg::way_mask_t  valid_mem [2**l2_dir_pkg::L1_SET_W];
	l2_dir_pkg::dir_state_t state;
	l2_dir_pkg::l1_set_t    clear_set;
	l2_dir_pkg::l1_tag_t    req_tag;
	l2_dir_pkg::l1_set_t    req_set;
	l2_dir_pkg::way_mask_t  lookup_hit;
	l2_dir_pkg::way_t       lookup_way;
	logic                   ready;
	logic                   is_dcache_load;
	logic                   update_dir;

	assign req_tag = req_addr_i[l2_dir_pkg::ADDR_W-1 -: l2_dir_pkg::L1_TAG_W];
	assign req_set = req_addr_i[l2_dir_pkg::L1_SET_W-1:0];
	assign ready   = (state == l2_dir_pkg::READY);

	// Only data cache loads bring a line into L1
	assign is_dcache_load = (req_unit_i == `UNIT_DCACHE)
		&& ((req_op_i == `OP_LOAD) || (req_op_i == `OP_LOAD_SYNC));
	assign update_dir = req_valid_i && !stall_i && ready && is_dcache_load
		&& (l2_hit_i || has_fill_i);

	always_comb
	begin
		lookup_way = '0;
		for (int w = 0; w < l2_dir_pkg::NUM_WAYS; w++)
		begin
			lookup_hit[w] = valid_mem[req_set][w] && (tag_mem[req_set][w] == req_tag);
			if (lookup_hit[w])
				lookup_way = l2_dir_pkg::way_t'(w);
		end
	end

	// Clear sequencer, one set per cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			state     <= l2_dir_pkg::CLEARING;
			clear_set <= '0;
		end
		else if (!stall_i && state == l2_dir_pkg::CLEARING)
		begin
			clear_set <= clear_set + 1'b1;
			if (clear_set == '1)
				state <= l2_dir_pkg::READY;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall_i && state == l2_dir_pkg::CLEARING)
			valid_mem[clear_set] <= '0;
		else if (update_dir)
			valid_mem[req_set][req_l1_way_i] <= 1'b1;
		if (update_dir)
			tag_mem[req_set][req_l1_way_i] <= req_tag;
	end

	// The lookup reads the arrays as they were before this cycle's update
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			l1_has_line_o <= 1'b0;
			l1_way_o      <= '0;
		end
		else if (!stall_i && ready)
		begin
			l1_has_line_o <= req_valid_i && (|lookup_hit);
			l1_way_o      <= lookup_way;
		end
	end

endmodule

// File: design/l2_dir_output.sv
// Output register of the directory stage; holds its value through a stall
// Assumes a one-hot or empty way hit mask
`timescale 1ns/1ps

module l2_dir_output (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   stall_i,
	input  logic                   req_valid_i,
	input  l2_dir_pkg::req_op_t    req_op_i,
	input  l2_dir_pkg::line_addr_t req_addr_i,
	input  logic                   has_fill_i,
	input  l2_dir_pkg::way_t       fill_way_i,
	input  l2_dir_pkg::way_mask_t  way_hit_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag0_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag1_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag2_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag3_i,
	output logic                   dir_valid_o,
	output l2_dir_pkg::req_op_t    dir_op_o,
	output l2_dir_pkg::line_addr_t dir_addr_o,
	output logic                   dir_cache_hit_o,
	output l2_dir_pkg::way_t       dir_hit_way_o,
	output l2_dir_pkg::l2_tag_t    dir_old_tag_o
);

	l2_dir_pkg::way_t    hit_way;
	l2_dir_pkg::way_t    tag_sel;
	l2_dir_pkg::l2_tag_t old_tag;
	logic                cache_hit;

	// One-hot to index, valid only when a single bit is set
	assign hit_way   = {way_hit_i[3] | way_hit_i[2], way_hit_i[3] | way_hit_i[1]};
	assign cache_hit = |way_hit_i;

	// The fill way names the line being replaced; otherwise the hit line
	assign tag_sel = has_fill_i ? fill_way_i : hit_way;

	always_comb
	begin
		case (tag_sel)
			2'd0: old_tag = l2_tag0_i;
			2'd1: old_tag = l2_tag1_i;
			2'd2: old_tag = l2_tag2_i;
			default: old_tag = l2_tag3_i;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			dir_valid_o     <= 1'b0;
			dir_op_o        <= '0;
			dir_addr_o      <= '0;
			dir_cache_hit_o <= 1'b0;
			dir_hit_way_o   <= '0;
			dir_old_tag_o   <= '0;
		end
		else if (!stall_i)
		begin
			dir_valid_o     <= req_valid_i;
			dir_op_o        <= req_op_i;
			dir_addr_o      <= req_addr_i;
			dir_cache_hit_o <= cache_hit;
			dir_hit_way_o   <= hit_way;
			dir_old_tag_o   <= old_tag;
		end
	end

endmodule

// File: design/l2_cache_dir.sv
// Directory stage of the L2 pipeline, one cycle from request to result
// Requests are taken only after the L1 directory has finished its clear
`timescale 1ns/1ps

module l2_cache_dir (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   stall_i,
	input  logic                   req_valid_i,
	input  l2_dir_pkg::unit_t      req_unit_i,
	input  l2_dir_pkg::req_op_t    req_op_i,
	input  l2_dir_pkg::line_addr_t req_addr_i,
	input  l2_dir_pkg::way_t       req_l1_way_i,
	input  logic                   has_fill_i,
	input  l2_dir_pkg::way_t       fill_way_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag0_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag1_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag2_i,
	input  l2_dir_pkg::l2_tag_t    l2_tag3_i,
	input  logic                   l2_valid0_i,
	input  logic                   l2_valid1_i,
	input  logic                   l2_valid2_i,
	input  logic                   l2_valid3_i,
	output logic                   dir_valid_o,
	output l2_dir_pkg::req_op_t    dir_op_o,
	output l2_dir_pkg::line_addr_t dir_addr_o,
	output logic                   dir_cache_hit_o,
	output l2_dir_pkg::way_t       dir_hit_way_o,
	output l2_dir_pkg::l2_tag_t    dir_old_tag_o,
	output logic                   dir_l1_has_line_o,
	output l2_dir_pkg::way_t       dir_l1_way_o,
	output logic                   dir_dirty0_o,
	output logic                   dir_dirty1_o,
	output logic                   dir_dirty2_o,
	output logic                   dir_dirty3_o
);

	l2_dir_pkg::way_mask_t way_hit;
	logic                  l2_hit;

	l2_way_state u_way_state (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.stall_i     (stall_i),
		.req_valid_i (req_valid_i),
		.req_op_i    (req_op_i),
		.req_addr_i  (req_addr_i),
		.has_fill_i  (has_fill_i),
		.fill_way_i  (fill_way_i),
		.l2_tag0_i   (l2_tag0_i),
		.l2_tag1_i   (l2_tag1_i),
		.l2_tag2_i   (l2_tag2_i),
		.l2_tag3_i   (l2_tag3_i),
		.l2_valid0_i (l2_valid0_i),
		.l2_valid1_i (l2_valid1_i),
		.l2_valid2_i (l2_valid2_i),
		.l2_valid3_i (l2_valid3_i),
		.way_hit_o   (way_hit),
		.l2_hit_o    (l2_hit),
		.dirty0_o    (dir_dirty0_o),
		.dirty1_o    (dir_dirty1_o),
		.dirty2_o    (dir_dirty2_o),
		.dirty3_o    (dir_dirty3_o)
	);

	l1_dir_tags u_l1_dir (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.stall_i       (stall_i),
		.req_valid_i   (req_valid_i),
		.req_unit_i    (req_unit_i),
		.req_op_i      (req_op_i),
		.req_addr_i    (req_addr_i),
		.req_l1_way_i  (req_l1_way_i),
		.has_fill_i    (has_fill_i),
		.l2_hit_i      (l2_hit),
		.l1_has_line_o (dir_l1_has_line_o),
		.l1_way_o      (dir_l1_way_o)
	);

	l2_dir_output u_output (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.stall_i         (stall_i),
		.req_valid_i     (req_valid_i),
		.req_op_i        (req_op_i),
		.req_addr_i      (req_addr_i),
		.has_fill_i      (has_fill_i),
		.fill_way_i      (fill_way_i),
		.way_hit_i       (way_hit),
		.l2_tag0_i       (l2_tag0_i),
		.l2_tag1_i       (l2_tag1_i),
		.l2_tag2_i       (l2_tag2_i),
		.l2_tag3_i       (l2_tag3_i),
		.dir_valid_o     (dir_valid_o),
		.dir_op_o        (dir_op_o),
		.dir_addr_o      (dir_addr_o),
		.dir_cache_hit_o (dir_cache_hit_o),
		.dir_hit_way_o   (dir_hit_way_o),
		.dir_old_tag_o   (dir_old_tag_o)
	);

endmodule

// File: sim/l2_cache_dir_assert.sv
// Concurrent checks on the directory stage, bound into every l2_cache_dir
// Expects the tag stage to present distinct tags for the four ways
`timescale 1ns/1ps

module l2_cache_dir_assert (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   stall_i,
	input  l2_dir_pkg::way_mask_t  way_hit_i,
	input  logic                   dir_valid_i,
	input  l2_dir_pkg::req_op_t    dir_op_i,
	input  l2_dir_pkg::line_addr_t dir_addr_i,
	input  logic                   dir_cache_hit_i,
	input  l2_dir_pkg::way_t       dir_hit_way_i,
	input  l2_dir_pkg::l2_tag_t    dir_old_tag_i,
	input  logic                   dir_l1_has_line_i,
	input  l2_dir_pkg::way_t       dir_l1_way_i,
	input  logic [3:0]             dir_dirty_i
);

	logic [41:0] result;

	// Every stage output in one vector
	assign result = {dir_valid_i, dir_op_i, dir_addr_i, dir_cache_hit_i, dir_hit_way_i,
		dir_old_tag_i, dir_l1_has_line_i, dir_l1_way_i, dir_dirty_i};

	hit_onehot: assert property (@(posedge clk) $onehot0(way_hit_i))
		else $error("More than one L2 way hit at once");

	valid_in_reset: assert property (@(posedge clk) !rst_n_i |=> !dir_valid_i)
		else $error("dir_valid_o is set while reset is held");

	// A stalled edge leaves the registered result untouched
	hold_in_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_i |=> $stable(result))
		else $error("Stage outputs changed during a stall");

endmodule

bind l2_cache_dir l2_cache_dir_assert u_assert (
	.clk               (clk),
	.rst_n_i           (rst_n_i),
	.stall_i           (stall_i),
	.way_hit_i         (way_hit),
	.dir_valid_i       (dir_valid_o),
	.dir_op_i          (dir_op_o),
	.dir_addr_i        (dir_addr_o),
	.dir_cache_hit_i   (dir_cache_hit_o),
	.dir_hit_way_i     (dir_hit_way_o),
	.dir_old_tag_i     (dir_old_tag_o),
	.dir_l1_has_line_i (dir_l1_has_line_o),
	.dir_l1_way_i      (dir_l1_way_o),
	.dir_dirty_i       ({dir_dirty3_o, dir_dirty2_o, dir_dirty1_o, dir_dirty0_o})
);

// File: sim/tb_l2_cache_dir.sv
// Table-driven testbench of the L2 directory stage, one table row per clock cycle
// Each row's result is checked 90 ns after the edge that captured it
`timescale 1ns/1ps
`include "l2_ops.svh"

module tb_l2_cache_dir;

	localparam int PERIOD        = 100;
	localparam int RST_CYCLES    = 5;
	localparam int SETTLE_CYCLES = 10;
	localparam int NUM_ROWS      = 17;
	// Marks a way whose tag the table leaves to a random value
	localparam l2_dir_pkg::l2_tag_t ANY = 12'hfff;

	logic clk;
	logic rst_n_i;
	logic stall_i;
	logic req_valid_i;
	l2_dir_pkg::unit_t      req_unit_i;
	l2_dir_pkg::req_op_t    req_op_i;
	l2_dir_pkg::line_addr_t req_addr_i;
	l2_dir_pkg::way_t       req_l1_way_i;
	logic                   has_fill_i;
	l2_dir_pkg::way_t       fill_way_i;
	l2_dir_pkg::l2_tag_t    l2_tag0_i, l2_tag1_i, l2_tag2_i, l2_tag3_i;
	logic                   l2_valid0_i, l2_valid1_i, l2_valid2_i, l2_valid3_i;
	logic                   dir_valid_o, dir_cache_hit_o, dir_l1_has_line_o;
	l2_dir_pkg::req_op_t    dir_op_o;
	l2_dir_pkg::line_addr_t dir_addr_o;
	l2_dir_pkg::way_t       dir_hit_way_o, dir_l1_way_o;
	l2_dir_pkg::l2_tag_t    dir_old_tag_o;
	logic                   dir_dirty0_o, dir_dirty1_o, dir_dirty2_o, dir_dirty3_o;

	// Stimulus columns
	l2_dir_pkg::req_op_t    t_op [NUM_ROWS];
	l2_dir_pkg::unit_t      t_unit [NUM_ROWS];
	l2_dir_pkg::line_addr_t t_addr [NUM_ROWS];
	l2_dir_pkg::way_t       t_l1_way [NUM_ROWS];
	logic                   t_fill [NUM_ROWS];
	l2_dir_pkg::way_t       t_fill_way [NUM_ROWS];
	l2_dir_pkg::l2_tag_t    t_tag [NUM_ROWS][4];
	logic [3:0]             t_valid [NUM_ROWS];
	logic                   t_stall [NUM_ROWS];
	// Expected columns
	l2_dir_pkg::req_op_t    e_op [NUM_ROWS];
	l2_dir_pkg::line_addr_t e_addr [NUM_ROWS];
	logic                   e_hit [NUM_ROWS];
	l2_dir_pkg::way_t       e_way [NUM_ROWS];
	l2_dir_pkg::l2_tag_t    e_old_tag [NUM_ROWS];
	logic                   e_l1_has [NUM_ROWS];
	l2_dir_pkg::way_t       e_l1_way [NUM_ROWS];
	logic [3:0]             e_dirty [NUM_ROWS];

	integer seed;
	int     n_rows;
	int     errors;

	l2_cache_dir UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic check_bit(input string where, input string name, input logic actual,
		input logic expected);
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] %0t: %s %s is %0b, expected %0b", $time, where, name, actual,
				expected);
		end
	endtask

	task automatic check_way(input string where, input string name,
		input l2_dir_pkg::way_t actual, input l2_dir_pkg::way_t expected);
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] %0t: %s %s is %0d, expected %0d", $time, where, name, actual,
				expected);
		end
	endtask

	task automatic check_tag(input string where, input string name,
		input l2_dir_pkg::l2_tag_t actual, input l2_dir_pkg::l2_tag_t expected);
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] %0t: %s %s is %h, expected %h", $time, where, name, actual,
				expected);
		end
	endtask

	task automatic check_op(input string where, input string name,
		input l2_dir_pkg::req_op_t actual, input l2_dir_pkg::req_op_t expected);
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] %0t: %s %s is %0d, expected %0d", $time, where, name, actual,
				expected);
		end
	endtask

	task automatic check_addr(input string where, input string name,
		input l2_dir_pkg::line_addr_t actual, input l2_dir_pkg::line_addr_t expected);
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] %0t: %s %s is %h, expected %h", $time, where, name, actual,
				expected);
		end
	endtask

	// A stall row expects what the row before it produced
	task automatic add_row(input l2_dir_pkg::req_op_t op, input l2_dir_pkg::unit_t unit,
		input l2_dir_pkg::line_addr_t addr, input l2_dir_pkg::way_t l1_way, input logic fill,
		input l2_dir_pkg::way_t fill_way, input l2_dir_pkg::l2_tag_t tag0, tag1, tag2, tag3,
		input logic [3:0] valid, input logic stall, input logic hit,
		input l2_dir_pkg::way_t hit_way, input l2_dir_pkg::way_t old_way, input logic l1_has,
		input l2_dir_pkg::way_t l1_way_exp, input logic [3:0] dirty);
		l2_dir_pkg::l2_tag_t tags [4];
		tags[0] = tag0;
		tags[1] = tag1;
		tags[2] = tag2;
		tags[3] = tag3;
		// Random tags carry the top bit and the way number, so they never match a table address
		for (int w = 0; w < 4; w++)
			if (tags[w] == ANY)
				tags[w] = {1'b1, 2'(w), 9'($random(seed))};
		t_op[n_rows]       = op;
		t_unit[n_rows]     = unit;
		t_addr[n_rows]     = addr;
		t_l1_way[n_rows]   = l1_way;
		t_fill[n_rows]     = fill;
		t_fill_way[n_rows] = fill_way;
		t_valid[n_rows]    = valid;
		t_stall[n_rows]    = stall;
		for (int w = 0; w < 4; w++)
			t_tag[n_rows][w] = tags[w];
		if (stall && n_rows > 0)
		begin
			e_op[n_rows]      = e_op[n_rows - 1];
			e_addr[n_rows]    = e_addr[n_rows - 1];
			e_hit[n_rows]     = e_hit[n_rows - 1];
			e_way[n_rows]     = e_way[n_rows - 1];
			e_old_tag[n_rows] = e_old_tag[n_rows - 1];
			e_l1_has[n_rows]  = e_l1_has[n_rows - 1];
			e_l1_way[n_rows]  = e_l1_way[n_rows - 1];
			e_dirty[n_rows]   = e_dirty[n_rows - 1];
		end
		else
		begin
			e_op[n_rows]      = op;
			e_addr[n_rows]    = addr;
			e_hit[n_rows]     = hit;
			e_way[n_rows]     = hit_way;
			e_old_tag[n_rows] = tags[old_way];
			e_l1_has[n_rows]  = l1_has;
			e_l1_way[n_rows]  = l1_way_exp;
			e_dirty[n_rows]   = dirty;
		end
		n_rows++;
	endtask

	// Columns: op, unit, addr, L1 way, fill, fill way / tags 0-3, valids, stall /
	// hit, hit way, old tag way, L1 has line, L1 way, dirty bits 3-0
	task automatic build_table();
		add_row(`OP_LOAD, `UNIT_DCACHE, 16'h1234, 2'd2, 1'b0, 2'd0,
			12'h123, ANY, ANY, ANY, 4'b1111, 1'b0, 1'b1, 2'd0, 2'd0, 1'b0, 2'd0, 4'b0000);
		add_row(`OP_STORE, `UNIT_DCACHE, 16'h1234, 2'd0, 1'b0, 2'd0,
			12'h123, ANY, ANY, ANY, 4'b1111, 1'b0, 1'b1, 2'd0, 2'd0, 1'b1, 2'd2, 4'b0000 | 4'b0001);
		add_row(`OP_LOAD, `UNIT_ICACHE, 16'h2345, 2'd3, 1'b0, 2'd0,
			ANY, 12'h234, ANY, ANY, 4'b1111, 1'b0, 1'b1, 2'd1, 2'd1, 1'b0, 2'd0, 4'b0000);
		// The instruction fetch above left the L1 copy alone
		add_row(`OP_LOAD, `UNIT_DCACHE, 16'h2345, 2'd1, 1'b0, 2'd0,
			ANY, 12'h234, ANY, ANY, 4'b1111, 1'b0, 1'b1, 2'd1, 2'd1, 1'b0, 2'd0, 4'b0000);
		// A stalled load must not write its line into L1 way 3
		add_row(`OP_LOAD, `UNIT_DCACHE, 16'h2345, 2'd3, 1'b0, 2'd0,
			ANY, 12'h234, ANY, ANY, 4'b1111, 1'b1, 1'b0, 2'd0, 2'd0, 1'b0, 2'd0, 4'b0000);
		add_row(`OP_LOAD, `UNIT_DCACHE, 16'h2345, 2'd1, 1'b0, 2'd0,
			ANY, 12'h234, ANY, ANY, 4'b1111, 1'b0, 1'b1, 2'd1, 2'd1, 1'b1, 2'd1, 4'b0000);
		add_row(`OP_STORE, `UNIT_DCACHE, 16'h4566, 2'd0, 1'b1, 2'd2,
			ANY, ANY, 12'h0ab, ANY, 4'b1111, 1'b0, 1'b0, 2'd0, 2'd2, 1'b0, 2'd0, 4'b0100);
		add_row(`OP_LOAD, `UNIT_DCACHE, 16'h5677, 2'd0, 1'b1, 2'd3,
			ANY, ANY, ANY, 12'h0cd, 4'b1111, 1'b0, 1'b0, 2'd0, 2'd3, 1'b0, 2'd0, 4'b0000);
		add_row(`OP_LOAD, `UNIT_DCACHE, 16'h4566, 2'd1, 1'b0, 2'd0,
			ANY, ANY, 12'h456, ANY, 4'b1111, 1'b0, 1'b1, 2'd2, 2'd2, 1'b0, 2'd0, 4'b0100);
		add_row(`OP_FLUSH, `UNIT_DCACHE, 16'h4566, 2'd0, 1'b0, 2'd0,
			ANY, ANY, 12'h456, ANY, 4'b1111, 1'b0, 1'b1, 2'd2, 2'd2, 1'b1, 2'd1, 4'b0000);
		// Way 0 matches but is invalid, so neither hit nor dirty shows
		add_row(`OP_LOAD, `UNIT_ICACHE, 16'h1234, 2'd0, 1'b0, 2'd0,
			12'h123, ANY, ANY, ANY, 4'b1110, 1'b0, 1'b0, 2'd0, 2'd0, 1'b1, 2'd2, 4'b0000);
		add_row(`OP_LOAD, `UNIT_DCACHE, 16'h1234, 2'd2, 1'b0, 2'd0,
			12'h123, ANY, ANY, ANY, 4'b1111, 1'b0, 1'b1, 2'd0, 2'd0, 1'b1, 2'd2, 4'b0001);
		add_row(`OP_FLUSH, `UNIT_DCACHE, 16'h1234, 2'd0, 1'b0, 2'd0,
			12'h123, ANY, ANY, ANY, 4'b1111, 1'b0, 1'b1, 2'd0, 2'd0, 1'b1, 2'd2, 4'b0000);
		add_row(`OP_STORE_SYNC, `UNIT_DCACHE, 16'h6788, 2'd0, 1'b0, 2'd0,
			ANY, ANY, ANY, 12'h678, 4'b1111, 1'b0, 1'b1, 2'd3, 2'd3, 1'b0, 2'd0, 4'b1000);
		add_row(`OP_FLUSH, `UNIT_DCACHE, 16'h6788, 2'd0, 1'b0, 2'd0,
			ANY, ANY, ANY, 12'h678, 4'b1111, 1'b1, 1'b0, 2'd0, 2'd0, 1'b0, 2'd0, 4'b0000);
		add_row(`OP_STORE, `UNIT_DCACHE, 16'h2345, 2'd0, 1'b0, 2'd0,
			ANY, 12'h234, ANY, ANY, 4'b1111, 1'b0, 1'b1, 2'd1, 2'd1, 1'b1, 2'd1, 4'b0010);
		add_row(`OP_LOAD_SYNC, `UNIT_DCACHE, 16'h6788, 2'd0, 1'b0, 2'd0,
			ANY, ANY, ANY, 12'h678, 4'b1111, 1'b0, 1'b1, 2'd3, 2'd3, 1'b0, 2'd0, 4'b1000);
	endtask

	task automatic drive_row(input int i);
		req_valid_i  = 1'b1;
		stall_i      = t_stall[i];
		req_op_i     = t_op[i];
		req_unit_i   = t_unit[i];
		req_addr_i   = t_addr[i];
		req_l1_way_i = t_l1_way[i];
		has_fill_i   = t_fill[i];
		fill_way_i   = t_fill_way[i];
		l2_tag0_i    = t_tag[i][0];
		l2_tag1_i    = t_tag[i][1];
		l2_tag2_i    = t_tag[i][2];
		l2_tag3_i    = t_tag[i][3];
		{l2_valid3_i, l2_valid2_i, l2_valid1_i, l2_valid0_i} = t_valid[i];
	endtask

	task automatic check_row(input int i);
		string where;
		where = $sformatf("row %0d", i);
		check_bit(where, "dir_valid_o", dir_valid_o, 1'b1);
		check_op(where, "dir_op_o", dir_op_o, e_op[i]);
		check_addr(where, "dir_addr_o", dir_addr_o, e_addr[i]);
		check_bit(where, "dir_cache_hit_o", dir_cache_hit_o, e_hit[i]);
		check_way(where, "dir_hit_way_o", dir_hit_way_o, e_way[i]);
		check_tag(where, "dir_old_tag_o", dir_old_tag_o, e_old_tag[i]);
		check_bit(where, "dir_l1_has_line_o", dir_l1_has_line_o, e_l1_has[i]);
		check_way(where, "dir_l1_way_o", dir_l1_way_o, e_l1_way[i]);
		check_bit(where, "dir_dirty0_o", dir_dirty0_o, e_dirty[i][0]);
		check_bit(where, "dir_dirty1_o", dir_dirty1_o, e_dirty[i][1]);
		check_bit(where, "dir_dirty2_o", dir_dirty2_o, e_dirty[i][2]);
		check_bit(where, "dir_dirty3_o", dir_dirty3_o, e_dirty[i][3]);
	endtask

	task automatic check_idle(input string where);
		check_bit(where, "dir_valid_o", dir_valid_o, 1'b0);
		check_op(where, "dir_op_o", dir_op_o, 3'd0);
		check_addr(where, "dir_addr_o", dir_addr_o, 16'h0000);
		check_bit(where, "dir_cache_hit_o", dir_cache_hit_o, 1'b0);
		check_way(where, "dir_hit_way_o", dir_hit_way_o, 2'd0);
		check_tag(where, "dir_old_tag_o", dir_old_tag_o, 12'h000);
		check_bit(where, "dir_l1_has_line_o", dir_l1_has_line_o, 1'b0);
		check_way(where, "dir_l1_way_o", dir_l1_way_o, 2'd0);
		check_bit(where, "dirty bits", dir_dirty0_o | dir_dirty1_o | dir_dirty2_o | dir_dirty3_o,
			1'b0);
	endtask

	initial
	begin
		seed         = 32'h6da8_6f01;
		errors       = 0;
		n_rows       = 0;
		rst_n_i      = 1'b0;
		stall_i      = 1'b0;
		req_valid_i  = 1'b0;
		req_unit_i   = '0;
		req_op_i     = '0;
		req_addr_i   = '0;
		req_l1_way_i = '0;
		has_fill_i   = 1'b0;
		fill_way_i   = '0;
		l2_tag0_i    = '0;
		l2_tag1_i    = '0;
		l2_tag2_i    = '0;
		l2_tag3_i    = '0;
		{l2_valid3_i, l2_valid2_i, l2_valid1_i, l2_valid0_i} = 4'b0000;
		build_table();
		repeat (RST_CYCLES) @(posedge clk);
		#10;
		check_idle("in reset");
		rst_n_i = 1'b1;
		// The L1 directory clears its sets before it takes requests
		repeat (SETTLE_CYCLES) @(posedge clk);
		#10;
		check_idle("after reset");
		// Row i is driven in cycle i and checked at the end of cycle i+1
		for (int i = 0; i <= n_rows; i++)
		begin
			@(posedge clk);
			#10;
			if (i < n_rows)
				drive_row(i);
			else
				req_valid_i = 1'b0;
			#80;
			if (i > 0)
				check_row(i - 1);
		end
		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		#((RST_CYCLES + SETTLE_CYCLES + NUM_ROWS + 20) * PERIOD);
		$display("Watchdog: the run timed out before the table was finished");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
design/l2_dir_pkg.sv
design/l2_way_state.sv
design/l1_dir_tags.sv
design/l2_dir_output.sv
design/l2_cache_dir.sv
sim/l2_cache_dir_assert.sv
sim/tb_l2_cache_dir.sv

// File: run.sh
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_l2_cache_dir --Mdir obj_dir -o tb_l2_cache_dir > build.log 2>&1 \
	&& ./obj_dir/tb_l2_cache_dir > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
